// File: filelist.f
design/pma_pkg.sv
design/pma_region_match.sv
design/pma_attr_check.sv
design/pma_stats.sv
design/pma_mpu.sv
design/pma_top.sv
sim/pma_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PMA checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module pma_tb -o pma_sim

out=$(./obj_dir/pma_sim)
echo "$out"

# Pass only when the testbench reports success
echo "$out" | grep -q "ALL TESTS PASSED"

// File: sim/pma_tb.sv
// Random testbench for pma_top with NUM_REGIONS 8 and a fixed seed
// Inputs change on the falling edge and outputs are sampled 1 ns later
// Run length is bounded by a cycle limit derived from the test schedule

`timescale 1ns/1ns
`default_nettype none

module pma_tb
  import pma_pkg::*;
;

  localparam int NUM_REGIONS = 8;
  // Scheduled cycles per test, back-pressure counted at two per transaction
  localparam int T1_CYC = 40 + 8;
  localparam int T2_CYC = 16 + 96 + 8;
  localparam int T3_CYC = 8 + 64 + 8;
  localparam int T4_CYC = 2 * 200 + 8;
  localparam int SCHED_CYCLES = 16 + T1_CYC + T2_CYC + T3_CYC + T4_CYC;
  localparam int LIMIT = 2 * SCHED_CYCLES + 200;

  logic                   clk;
  logic                   arst_n;
  logic                   cfg_we;
  logic [IDX_W-1:0]       cfg_idx;
  pma_region_t            cfg_region;
  logic                   trans_valid;
  trans_t                 trans;
  logic                   trans_ready;
  logic                   resp_valid;
  pma_resp_t              resp;
  logic                   resp_ready;
  pma_stats_t             stats;
  logic [NUM_REGIONS-1:0] region_hit;

  // Reference model state
  pma_region_t            m_table [NUM_REGIONS];
  pma_resp_t              exp_q [$];
  pma_stats_t             exp_stats;
  logic [NUM_REGIONS-1:0] exp_hit;
  int errors = 0;
  int err_base = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int n_sent = 0;
  int n_resp = 0;
  int cycles = 0;

  pma_top #(
    .NUM_REGIONS (NUM_REGIONS)
  ) pma_top_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg_we      (cfg_we),
    .cfg_idx     (cfg_idx),
    .cfg_region  (cfg_region),
    .trans_valid (trans_valid),
    .trans       (trans),
    .trans_ready (trans_ready),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_ready  (resp_ready),
    .stats       (stats),
    .region_hit  (region_hit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog, ends the run if the tests stall
  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d responses pending", cycles, exp_q.size());
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic permitted(input pma_region_t r, input access_e k);
    case (k)
      ACC_READ:  return r.readable;
      ACC_WRITE: return r.writable;
      ACC_EXEC:  return r.executable;
      default:   return 1'b0;
    endcase
  endfunction

  // Lowest matching region decides, otherwise only execute faults
  function automatic pma_resp_t predict(input trans_t t, output int n_match);
    pma_resp_t r;
    r = '0;
    n_match = 0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (m_table[i].valid && (((t.addr ^ m_table[i].base) & m_table[i].mask) == '0)) begin
        if (n_match == 0) begin
          r.have_match = 1'b1;
          r.match_idx  = IDX_W'(i);
          r.fault      = !permitted(m_table[i], t.kind);
        end
        n_match++;
      end
    end
    if (n_match == 0) begin
      r.fault = (t.kind == ACC_EXEC);
    end
    return r;
  endfunction

  task automatic compare_resp(input pma_resp_t got, input pma_resp_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t signal=resp got=%h expected=%h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic compare_stats(input pma_stats_t got, input pma_stats_t exp);
    if (got !== exp) begin
      $display("FAIL time=%0t signal=stats got=%h expected=%h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic compare_hit(input logic [NUM_REGIONS-1:0] got,
                             input logic [NUM_REGIONS-1:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t signal=region_hit got=%b expected=%b", $time, got, exp);
      errors++;
    end
  endtask

  // Sees what the next rising edge will do, called 1 ns after the falling edge
  task automatic observe(output bit accepted);
    pma_resp_t exp;
    int n;
    accepted = 1'b0;
    if (resp_valid && resp_ready) begin
      // Every consumed response counts, expected or not
      n_resp++;
      if (exp_q.size() == 0) begin
        $display("Response at %0t arrived with no transaction pending", $time);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        compare_resp(resp, exp);
      end
    end
    if (trans_valid && trans_ready) begin
      // Lookup uses the table before a same-cycle write
      exp = predict(trans, n);
      exp_q.push_back(exp);
      n_sent++;
      accepted = 1'b1;
      if (n == 0 && exp_stats.nomatch != '1) exp_stats.nomatch = exp_stats.nomatch + 1'b1;
      if (n == 1 && exp_stats.single != '1) exp_stats.single = exp_stats.single + 1'b1;
      if (n >= 2 && exp_stats.multi != '1) exp_stats.multi = exp_stats.multi + 1'b1;
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (exp.have_match && exp.match_idx == IDX_W'(i)) exp_hit[i] = 1'b1;
      end
    end
    // Out-of-range writes are dropped
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (cfg_we && cfg_idx == IDX_W'(i)) m_table[i] = cfg_region;
    end
  endtask

  // Holds the transaction until the DUT takes it
  task automatic send_trans(input trans_t t, input int ready_pct);
    bit acc;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      cfg_we      = 1'b0;
      trans_valid = 1'b1;
      trans       = t;
      resp_ready  = int'($urandom_range(99, 0)) < ready_pct;
      #1;
      observe(acc);
    end
  endtask

  task automatic write_cfg(input int idx, input pma_region_t r);
    bit acc;
    @(negedge clk);
    trans_valid = 1'b0;
    resp_ready  = 1'b1;
    cfg_we      = 1'b1;
    cfg_idx     = IDX_W'(idx);
    cfg_region  = r;
    #1;
    observe(acc);
  endtask

  // Keeps watching one cycle past the last expected response
  task automatic drain();
    bit acc;
    int idle;
    idle = 0;
    while (idle < 2) begin
      @(negedge clk);
      cfg_we      = 1'b0;
      trans_valid = 1'b0;
      resp_ready  = 1'b1;
      #1;
      observe(acc);
      if (exp_q.size() == 0) begin
        idle++;
      end
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_base) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, errors - err_base);
    end
    err_base = errors;
  endtask

  // Address inside the overlap window used by tests 3 and 4
  function automatic trans_t window_trans();
    trans_t t;
    t.addr = 32'h9000_0000 | ($urandom & 32'h3FFF);
    t.kind = access_e'(2'($urandom_range(2, 0)));
    return t;
  endfunction

  initial begin
    trans_t      t;
    pma_region_t r;
    int          sel;
    int          size_log;
    void'($urandom(32'ha3c8));
    arst_n      = 1'b0;
    cfg_we      = 1'b0;
    cfg_idx     = '0;
    cfg_region  = '0;
    trans_valid = 1'b0;
    trans       = '0;
    resp_ready  = 1'b1;
    for (int i = 0; i < NUM_REGIONS; i++) m_table[i] = '0;
    exp_stats = '0;
    exp_hit   = '0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // Empty table, every lookup misses
    @(negedge clk);
    #1;
    if (trans_ready !== 1'b1 || resp_valid !== 1'b0) begin
      $display("Handshake state after reset is wrong, trans_ready %b resp_valid %b",
               trans_ready, resp_valid);
      errors++;
    end
    compare_stats(stats, exp_stats);
    compare_hit(region_hit, exp_hit);
    for (int k = 0; k < 40; k++) begin
      t.addr = $urandom;
      t.kind = access_e'(2'($urandom_range(2, 0)));
      send_trans(t, 100);
    end
    drain();
    compare_stats(stats, exp_stats);
    compare_hit(region_hit, exp_hit);
    end_test("reset_defaults");

    // Disjoint regions, base carries the index, writes 8 to 15 are ignored
    for (int k = 0; k < 16; k++) begin
      r.base       = {16'h4000, 4'(k), 12'h000};
      r.mask       = ($urandom_range(1, 0) != 0) ? 32'hFFFF_F000 : 32'hFFFF_FF00;
      r.valid      = ($urandom_range(7, 0) != 0);
      r.readable   = 1'($urandom_range(1, 0));
      r.writable   = 1'($urandom_range(1, 0));
      r.executable = 1'($urandom_range(1, 0));
      write_cfg(k, r);
    end
    for (int k = 0; k < 96; k++) begin
      sel    = int'($urandom_range(15, 0));
      t.addr = {16'h4000, 4'(sel), 12'($urandom)};
      if ($urandom_range(7, 0) == 0) t.addr = $urandom;
      t.kind = access_e'(2'($urandom_range(2, 0)));
      send_trans(t, 100);
    end
    drain();
    compare_stats(stats, exp_stats);
    end_test("disjoint_regions");

    // Aligned blocks of random size in one 16 KB window
    for (int k = 0; k < NUM_REGIONS; k++) begin
      size_log     = int'($urandom_range(14, 8));
      r.mask       = ~((32'd1 << size_log) - 32'd1);
      r.base       = (32'h9000_0000 | ($urandom & 32'h3FFF)) & r.mask;
      r.valid      = 1'b1;
      r.readable   = 1'($urandom_range(1, 0));
      r.writable   = 1'($urandom_range(1, 0));
      r.executable = 1'($urandom_range(1, 0));
      write_cfg(k, r);
    end
    for (int k = 0; k < 64; k++) send_trans(window_trans(), 100);
    drain();
    compare_stats(stats, exp_stats);
    end_test("overlap_priority");

    // Random stalls on resp_ready
    n_sent = 0;
    n_resp = 0;
    for (int k = 0; k < 200; k++) send_trans(window_trans(), 40);
    drain();
    if (n_resp != n_sent) begin
      $display("Transactions lost or duplicated, %0d accepted, %0d responses", n_sent, n_resp);
      errors++;
    end
    end_test("back_pressure");

    compare_hit(region_hit, exp_hit);
    compare_stats(stats, exp_stats);
    end_test("final_stats");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/pma_top.sv
// PMA checker top level, MPU plus statistics
// NUM_REGIONS ranges from 1 to MAX_REGIONS

`timescale 1ns/1ns
`default_nettype none

module pma_top
  import pma_pkg::*;
#(
  parameter int NUM_REGIONS = 8
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cfg_we,
  input  logic [IDX_W-1:0]       cfg_idx,
  input  pma_region_t            cfg_region,
  input  logic                   trans_valid,
  input  trans_t                 trans,
  output logic                   trans_ready,
  output logic                   resp_valid,
  output pma_resp_t              resp,
  input  logic                   resp_ready,
  output pma_stats_t             stats,
  output logic [NUM_REGIONS-1:0] region_hit
);

  // Acceptance pulse and lookup result toward the statistics
  logic        activate;
  pma_status_t status;

  pma_mpu #(
    .NUM_REGIONS (NUM_REGIONS)
  ) mpu_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg_we      (cfg_we),
    .cfg_idx     (cfg_idx),
    .cfg_region  (cfg_region),
    .trans_valid (trans_valid),
    .trans       (trans),
    .trans_ready (trans_ready),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_ready  (resp_ready),
    .activate    (activate),
    .status      (status)
  );

  pma_stats #(
    .NUM_REGIONS (NUM_REGIONS)
  ) stats_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .activate   (activate),
    .status     (status),
    .stats      (stats),
    .region_hit (region_hit)
  );

endmodule

`default_nettype wire

// File: design/pma_mpu.sv
// Region table, lookup and registered response with valid/ready flow control
// Lookup sees the table before a same-cycle configuration write
// Writes to indices at or above NUM_REGIONS are dropped

`timescale 1ns/1ns
`default_nettype none

module pma_mpu
  import pma_pkg::*;
#(
  parameter int NUM_REGIONS = MAX_REGIONS
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             cfg_we,
  input  logic [IDX_W-1:0] cfg_idx,
  input  pma_region_t      cfg_region,
  input  logic             trans_valid,
  input  trans_t           trans,
  output logic             trans_ready,
  output logic             resp_valid,
  output pma_resp_t        resp,
  input  logic             resp_ready,
  output logic             activate,
  output pma_status_t      status
);

  logic [NUM_REGIONS-1:0] region_valid;
  pma_region_t            region_data  [NUM_REGIONS];
  pma_region_t            region_table [NUM_REGIONS];
  pma_region_t            sel_region;
  logic                   fault;
  logic                   accept;

  // Valid bits are reset so the table starts empty
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      region_valid <= '0;
    end else if (cfg_we) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (cfg_idx == IDX_W'(i)) begin
          region_valid[i] <= cfg_region.valid;
        end
      end
    end
  end

  // Base, mask and permissions
  always_ff @(posedge clk) begin
    if (cfg_we) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (cfg_idx == IDX_W'(i)) begin
          region_data[i] <= cfg_region;
        end
      end
    end
  end

  // Table as seen by the lookup, valid taken from the reset flops
  always_comb begin
    for (int i = 0; i < NUM_REGIONS; i++) begin
      region_table[i]       = region_data[i];
      region_table[i].valid = region_valid[i];
    end
  end

  pma_region_match #(
    .NUM_REGIONS (NUM_REGIONS)
  ) region_match_i (
    .region_table (region_table),
    .addr         (trans.addr),
    .status       (status)
  );

  // Entry chosen by the priority pick
  always_comb begin
    sel_region = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (status.match_idx == IDX_W'(i)) begin
        sel_region = region_table[i];
      end
    end
  end

  pma_attr_check attr_check_i (
    .kind   (trans.kind),
    .region (sel_region),
    .status (status),
    .fault  (fault)
  );

  // Free slot, or the held response leaves this cycle
  assign trans_ready = !resp_valid || resp_ready;
  assign accept      = trans_valid && trans_ready;
  assign activate    = accept;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid <= 1'b0;
    end else if (accept) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      resp <= '{fault: fault, have_match: status.have_match, match_idx: status.match_idx};
    end
  end

  // Stalled response must not change or drop
  a_resp_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
  ) else $error("response changed under back-pressure");

endmodule

`default_nettype wire

// File: design/pma_stats.sv
// Lookup statistics, updated once per accepted transaction
// Counters saturate, region_hit bits are sticky until reset
// Number of matches comes from a popcount of match_list

`timescale 1ns/1ns
`default_nettype none

module pma_stats
  import pma_pkg::*;
#(
  parameter int NUM_REGIONS = MAX_REGIONS
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   activate,
  input  pma_status_t            status,
  output pma_stats_t             stats,
  output logic [NUM_REGIONS-1:0] region_hit
);

  // Wide enough to hold MAX_REGIONS
  logic [IDX_W:0] num_matches;

  always_comb begin
    num_matches = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      num_matches = num_matches + (IDX_W + 1)'(status.match_list[i]);
    end
  end

  // Three-way classification, each counter stops at all ones
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stats <= '0;
    end else if (activate) begin
      if (num_matches == '0) begin
        if (stats.nomatch != '1) begin
          stats.nomatch <= stats.nomatch + 1'b1;
        end
      end else if (num_matches == (IDX_W + 1)'(1)) begin
        if (stats.single != '1) begin
          stats.single <= stats.single + 1'b1;
        end
      end else begin
        if (stats.multi != '1) begin
          stats.multi <= stats.multi + 1'b1;
        end
      end
    end
  end

  // Mark the region that was selected, not every overlapping one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      region_hit <= '0;
    end else if (activate && status.have_match) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (status.match_idx == IDX_W'(i)) begin
          region_hit[i] <= 1'b1;
        end
      end
    end
  end

  // Counters only ever move up, hit bits never clear
  a_monotonic: assert property (
    @(posedge clk) disable iff (!arst_n)
    (stats.nomatch >= $past(stats.nomatch)) &&
    (stats.single >= $past(stats.single)) &&
    (stats.multi >= $past(stats.multi)) &&
    ((region_hit & $past(region_hit)) == $past(region_hit))
  ) else $error("statistics decreased");

endmodule

`default_nettype wire

// File: design/pma_attr_check.sv
// Permission check for one transaction
// Without a match, reads and writes pass and executes fault
// Illegal access kind encodings always fault

`timescale 1ns/1ns
`default_nettype none

module pma_attr_check
  import pma_pkg::*;
(
  input  access_e     kind,
  input  pma_region_t region,
  input  pma_status_t status,
  output logic        fault
);

  logic region_fault;
  logic default_fault;

  // Selected region must grant the permission for this kind
  always_comb begin
    case (kind)
      ACC_READ: begin
        region_fault = !region.readable;
      end
      ACC_WRITE: begin
        region_fault = !region.writable;
      end
      ACC_EXEC: begin
        region_fault = !region.executable;
      end
      default: begin
        region_fault = 1'b1;
      end
    endcase
  end

  // No-match defaults
  always_comb begin
    case (kind)
      ACC_READ,
      ACC_WRITE: begin
        default_fault = 1'b0;
      end
      default: begin
        default_fault = 1'b1;
      end
    endcase
  end

  // have_match decides which rule set applies
  assign fault = status.have_match ? region_fault : default_fault;

endmodule

`default_nettype wire

// File: design/pma_region_match.sv
// Combinational address lookup against the region table
// Lowest-numbered matching region wins when regions overlap
// Only entries below NUM_REGIONS are examined

`timescale 1ns/1ns
`default_nettype none

module pma_region_match
  import pma_pkg::*;
#(
  parameter int NUM_REGIONS = MAX_REGIONS
) (
  input  pma_region_t       region_table [NUM_REGIONS],
  input  logic [ADDR_W-1:0] addr,
  output pma_status_t       status
);

  logic [MAX_REGIONS-1:0] match_list;
  logic                   found;
  logic [IDX_W-1:0]       first_idx;

  // One compare per region, unused upper bits stay zero
  always_comb begin
    match_list = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      match_list[i] = region_table[i].valid &&
                      ((addr & region_table[i].mask) ==
                       (region_table[i].base & region_table[i].mask));
    end
  end

  // Priority pick, first hit from index 0 upward
  always_comb begin
    found     = 1'b0;
    first_idx = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (match_list[i] && !found) begin
        found     = 1'b1;
        first_idx = IDX_W'(i);
      end
    end
  end

  assign status = '{match_list: match_list, have_match: found, match_idx: first_idx};

  // Lookup consistency, skipped while the address is still undriven
  always_comb begin
    if (!$isunknown(addr)) begin
      assert (status.have_match == (|status.match_list))
        else $error("have_match disagrees with match_list");
      assert (int'(status.match_idx) < NUM_REGIONS)
        else $error("match_idx %0d out of range", status.match_idx);
      assert ((status.match_list >> NUM_REGIONS) == '0)
        else $error("match_list has bits above NUM_REGIONS");
    end
  end

endmodule

`default_nettype wire

// File: design/pma_pkg.sv
// Shared types for the PMA checker
// Region table holds at most MAX_REGIONS entries, indexed with IDX_W bits
// Statistics counters saturate at their all-ones value

`default_nettype none

package pma_pkg;

  localparam int MAX_REGIONS = 16;
  localparam int IDX_W       = 4;
  localparam int CNT_W       = 16;
  localparam int ADDR_W      = 32;

  // Access kind, 2'b11 is not a legal encoding
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } access_e;

  // Address matches when (addr & mask) == (base & mask)
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] mask;
    logic              valid;
    logic              readable;
    logic              writable;
    logic              executable;
  } pma_region_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    access_e           kind;
  } trans_t;

  // Lookup result, bits of match_list at or above NUM_REGIONS stay zero
  typedef struct packed {
    logic [MAX_REGIONS-1:0] match_list;
    logic                   have_match;
    logic [IDX_W-1:0]       match_idx;
  } pma_status_t;

  typedef struct packed {
    logic             fault;
    logic             have_match;
    logic [IDX_W-1:0] match_idx;
  } pma_resp_t;

  typedef struct packed {
    logic [CNT_W-1:0] nomatch;
    logic [CNT_W-1:0] single;
    logic [CNT_W-1:0] multi;
  } pma_stats_t;

endpackage

`default_nettype wire
